// ==== rtl/board_pkg.sv ====
// Board bus widths, the synchronised input bundle and seven-segment display types.
package board_pkg;

  // widths of the physical board buses.
  localparam int key_w = 4;
  localparam int sw_w  = 10;
  localparam int pad_w = 4;
  localparam int led_w = 10;

  // all asynchronous board inputs travel together as one 18-bit bundle.
  typedef struct packed {
    logic [key_w-1:0] key;
    logic [sw_w-1:0]  sw;
    logic [pad_w-1:0] pad;
  } board_in_t;

  // one hexadecimal value shown on a display.
  typedef logic [3:0] hex_digit_t;

  // active-low segment pattern for one display with segment g in bit 6.
  typedef logic [6:0] seg_t;

  // index 0 of the six displays is the rightmost one.
  typedef seg_t [5:0] seg_bank_t;

endpackage

// ==== rtl/io_map_pkg.sv ====
// Peripheral address map, CPU memory request struct, hex word union and scan position.
package io_map_pkg;

  // addresses of the peripheral window at the top of the 16-bit space.
  localparam logic [15:0] sw_addr     = 16'hFFFF;
  localparam logic [15:0] key_addr    = 16'hFFFE;
  localparam logic [15:0] ledr_addr   = 16'hFFFD;
  localparam logic [15:0] hex_h_addr  = 16'hFFFC;
  localparam logic [15:0] hex_l_addr  = 16'hFFFB;
  localparam logic [15:0] hcount_addr = 16'hFFFA;
  localparam logic [15:0] vcount_addr = 16'hFFF9;
  localparam logic [15:0] music_addr  = 16'hFFF8;
  localparam logic [15:0] pad_addr    = 16'hFFF7;

  // single-cycle memory port request from the CPU.
  // read data returns combinationally and is not part of the request.
  typedef struct packed {
    logic [15:0] addr;
    logic        wr_en;
    logic [15:0] wr_data;
  } mem_req_t;

  // the hex-low register is written as one word and shown as four digits.
  // digit 3 sits in the top nibble.
  typedef union packed {
    logic [15:0]                  raw;
    board_pkg::hex_digit_t [3:0]  digits;
  } hex_word_u;

  // current raster position.
  typedef struct packed {
    logic [15:0] hcount;
    logic [15:0] vcount;
  } scan_pos_t;

endpackage

// ==== rtl/input_sync.sv ====
// Two-stage synchroniser for the key, switch and drum pad input bundle.
`timescale 1ns/1ns

module input_sync (
  input  logic                 clk,
  input  logic                 reset_n,
  input  board_pkg::board_in_t raw,
  output board_pkg::board_in_t synced
);

  import board_pkg::*;

  // first stage may go metastable, the second one settles it.
  board_in_t stage1;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stage1 <= '0;
      synced <= '0;
    end else begin
      stage1 <= raw;
      synced <= stage1;
    end
  end

endmodule

// ==== rtl/scan_counter.sv ====
// Raster counter producing the horizontal and vertical scan position.
`timescale 1ns/1ns

module scan_counter #(
  parameter int H_TOTAL = 800,
  parameter int V_TOTAL = 525
) (
  input  logic                  clk,
  input  logic                  reset_n,
  output io_map_pkg::scan_pos_t pos
);

  logic h_last;
  logic v_last;

  // end of line and end of frame.
  assign h_last = (pos.hcount == 16'(H_TOTAL - 1));
  assign v_last = (pos.vcount == 16'(V_TOTAL - 1));

  // hcount advances every cycle.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pos.hcount <= '0;
    end else if (h_last) begin
      pos.hcount <= '0;
    end else begin
      pos.hcount <= pos.hcount + 16'd1;
    end
  end

  // vcount steps once per line, on the cycle hcount wraps.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pos.vcount <= '0;
    end else if (h_last) begin
      if (v_last) begin
        pos.vcount <= '0;
      end else begin
        pos.vcount <= pos.vcount + 16'd1;
      end
    end
  end

endmodule

// ==== rtl/seven_seg_decoder.sv ====
// Six-digit hexadecimal to active-low seven-segment decoder.
`timescale 1ns/1ns

module seven_seg_decoder (
  input  board_pkg::hex_digit_t [5:0] digits,
  output board_pkg::seg_bank_t        segs
);

  import board_pkg::*;

  // standard hex glyphs light a segment when its bit is 0.
  function automatic seg_t glyph(input hex_digit_t d);
    case (d)
      4'h0: glyph = 7'b1000000;
      4'h1: glyph = 7'b1111001;
      4'h2: glyph = 7'b0100100;
      4'h3: glyph = 7'b0110000;
      4'h4: glyph = 7'b0011001;
      4'h5: glyph = 7'b0010010;
      4'h6: glyph = 7'b0000010;
      4'h7: glyph = 7'b1111000;
      4'h8: glyph = 7'b0000000;
      4'h9: glyph = 7'b0010000;
      4'hA: glyph = 7'b0001000;
      4'hB: glyph = 7'b0000011;
      4'hC: glyph = 7'b1000110;
      4'hD: glyph = 7'b0100001;
      4'hE: glyph = 7'b0000110;
      default: glyph = 7'b0001110;
    endcase
  endfunction

  // each display decodes its own digit.
  always_comb begin
    for (int i = 0; i < 6; i++) begin
      segs[i] = glyph(digits[i]);
    end
  end

endmodule

// ==== rtl/io_mapping.sv ====
// CPU memory port decode, output registers, read multiplexer and display drive.
`timescale 1ns/1ns

module io_mapping (
  input  logic                  clk,
  input  logic                  reset_n,
  input  io_map_pkg::mem_req_t  req,
  output logic [15:0]           rd_data,
  input  board_pkg::board_in_t  inputs,
  input  io_map_pkg::scan_pos_t scan,
  output logic [9:0]            ledr,
  output logic [1:0]            music_ctrl,
  output board_pkg::seg_bank_t  hex_segs
);

  import board_pkg::*;
  import io_map_pkg::*;

  hex_word_u        hex_l;
  logic [7:0]       hex_h;
  hex_digit_t [5:0] digits;

  logic wr_hex_l;
  logic wr_hex_h;
  logic wr_ledr;
  logic wr_music;

  // a write lands only when the address hits a writable register.
  assign wr_hex_l = req.wr_en && (req.addr == hex_l_addr);
  assign wr_hex_h = req.wr_en && (req.addr == hex_h_addr);
  assign wr_ledr  = req.wr_en && (req.addr == ledr_addr);
  assign wr_music = req.wr_en && (req.addr == music_addr);

  // the low word is stored raw and read out as digits for the displays.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hex_l.raw <= '0;
    end else if (wr_hex_l) begin
      hex_l.raw <= req.wr_data;
    end
  end

  // the upper two displays keep only the low byte of the write.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hex_h <= '0;
    end else if (wr_hex_h) begin
      hex_h <= req.wr_data[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ledr <= '0;
    end else if (wr_ledr) begin
      ledr <= req.wr_data[led_w-1:0];
    end
  end

  // music control word for the audio engine.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      music_ctrl <= '0;
    end else if (wr_music) begin
      music_ctrl <= req.wr_data[1:0];
    end
  end

  // read data is combinational from the address; unmapped reads give zero.
  always_comb begin
    case (req.addr)
      hex_l_addr:  rd_data = hex_l.raw;
      hex_h_addr:  rd_data = 16'(hex_h);
      ledr_addr:   rd_data = 16'(ledr);
      sw_addr:     rd_data = 16'(inputs.sw);
      key_addr:    rd_data = 16'(inputs.key);
      pad_addr:    rd_data = 16'(inputs.pad);
      hcount_addr: rd_data = scan.hcount;
      vcount_addr: rd_data = scan.vcount;
      music_addr:  rd_data = 16'(music_ctrl);
      default:     rd_data = '0;
    endcase
  end

  // digits 5 and 4 come from the high byte, digits 3 to 0 from the low word.
  assign digits = {hex_h, hex_l.digits};

  seven_seg_decoder seven_seg_decoder_inst (
    .digits (digits),
    .segs   (hex_segs)
  );

endmodule

// ==== rtl/board_io_top.sv ====
// Board I/O subsystem top level joining synchroniser, scan counter and I/O map.
`timescale 1ns/1ns

module board_io_top #(
  parameter int H_TOTAL = 800,
  parameter int V_TOTAL = 525
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  io_map_pkg::mem_req_t mem_req,
  output logic [15:0]          rd_data,
  input  board_pkg::board_in_t board_in,
  output logic [9:0]           ledr,
  output logic [1:0]           music_ctrl,
  output board_pkg::seg_bank_t hex_segs
);

  import board_pkg::*;
  import io_map_pkg::*;

  board_in_t synced_in;
  scan_pos_t scan_pos;

  input_sync input_sync_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .raw     (board_in),
    .synced  (synced_in)
  );

  scan_counter #(
    .H_TOTAL (H_TOTAL),
    .V_TOTAL (V_TOTAL)
  ) scan_counter_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .pos     (scan_pos)
  );

  io_mapping io_mapping_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (mem_req),
    .rd_data    (rd_data),
    .inputs     (synced_in),
    .scan       (scan_pos),
    .ledr       (ledr),
    .music_ctrl (music_ctrl),
    .hex_segs   (hex_segs)
  );

endmodule

// ==== tests/board_io_properties.sv ====
// Concurrent assertions on the I/O map read decode, LED register and music register.
`timescale 1ns/1ns

module board_io_properties (
  input logic                 clk,
  input logic                 reset_n,
  input io_map_pkg::mem_req_t req,
  input logic [15:0]          rd_data,
  input logic [9:0]           ledr,
  input logic [1:0]           music_ctrl
);

  import io_map_pkg::*;

  int   fail_count = 0;
  logic mapped;

  assign mapped = req.addr inside {sw_addr, key_addr, ledr_addr, hex_h_addr, hex_l_addr,
                                   hcount_addr, vcount_addr, music_addr, pad_addr};

  unmapped_read_zero: assert property (@(posedge clk) disable iff (!reset_n)
    !mapped |-> rd_data == 16'h0000)
    else begin
      fail_count++;
      $error("read of an unmapped address returned nonzero data");
    end

  // ledr may only change on the edge that takes a write to its address.
  ledr_needs_write: assert property (@(posedge clk) disable iff (!reset_n)
    ledr != $past(ledr) |-> $past(req.wr_en && req.addr == ledr_addr))
    else begin
      fail_count++;
      $error("ledr changed without a write to its address");
    end

  music_held: assert property (@(posedge clk) disable iff (!reset_n)
    !(req.wr_en && req.addr == music_addr) |=> $stable(music_ctrl))
    else begin
      fail_count++;
      $error("music_ctrl changed without a write to its address");
    end

endmodule

bind io_mapping board_io_properties board_io_properties_inst (
  .clk        (clk),
  .reset_n    (reset_n),
  .req        (req),
  .rd_data    (rd_data),
  .ledr       (ledr),
  .music_ctrl (music_ctrl)
);

// ==== tests/board_io_tb.sv ====
// Stimulus-file testbench for the board I/O block with a register model and compare tasks.
`timescale 1ns/1ns

module board_io_tb;

  import board_pkg::*;
  import io_map_pkg::*;

  logic        clk;
  logic        reset_n;
  mem_req_t    mem_req;
  logic [15:0] rd_data;
  board_in_t   board_in;
  logic [9:0]  ledr;
  logic [1:0]  music_ctrl;
  seg_bank_t   hex_segs;

  // each record gives an operation, an address or input value, data and an expected value.
  logic [7:0]  rec_op [$];
  logic [31:0] rec_val [$];
  logic [31:0] rec_data [$];
  logic [31:0] rec_exp [$];

  // the register model follows the writes that the testbench issues.
  hex_word_u  hex_l_model;
  logic [7:0] hex_h_model;
  logic [9:0] ledr_model;
  logic [1:0] music_model;

  // active-low glyphs for 0 to F with segment g in the top bit.
  localparam seg_t glyph_table [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  int   errors;
  int   timeout_cycles;
  logic loaded;
  logic opened;

  board_io_top #(
    .H_TOTAL (20),
    .V_TOTAL (10)
  ) board_io_top_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .mem_req    (mem_req),
    .rd_data    (rd_data),
    .board_in   (board_in),
    .ledr       (ledr),
    .music_ctrl (music_ctrl),
    .hex_segs   (hex_segs)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // with below set, the value only has to be smaller than exp.
  task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
                            input logic below, input string what);
    if ($isunknown(got) || (below ? !(got < exp) : (got !== exp))) begin
      errors++;
      $display("** Error at %0t: %s gave 0x%04h, expected %s0x%04h", $time, what, got,
               below ? "below " : "", exp);
    end
  endtask

  task automatic check_segs(input seg_bank_t got, input seg_bank_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bits(input logic [9:0] got, input logic [9:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic seg_bank_t expected_segs();
    seg_bank_t segs;
    for (int k = 0; k < 4; k++) begin
      segs[k] = glyph_table[hex_l_model.digits[k]];
    end
    segs[4] = glyph_table[hex_h_model[3:0]];
    segs[5] = glyph_table[hex_h_model[7:4]];
    return segs;
  endfunction

  task automatic check_outputs();
    check_bits(ledr, ledr_model, "ledr");
    check_bits({8'b0, music_ctrl}, {8'b0, music_model}, "music_ctrl");
    check_segs(hex_segs, expected_segs(), "hex_segs");
  endtask

  task automatic load_records(output logic ok);
    int           fd;
    int           cnt;
    logic [7:0]   op;
    logic [31:0]  v;
    logic [31:0]  d;
    logic [31:0]  e;
    logic [959:0] rest;
    fd = $fopen("tests/board_io_stim.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        cnt = $fscanf(fd, "%s", op);
        if (cnt == 1 && op == "#") begin
          cnt = $fgets(rest, fd);
        end else if (cnt == 1) begin
          cnt = $fscanf(fd, "%h %h %h", v, d, e);
          rec_op.push_back(op);
          rec_val.push_back(v);
          rec_data.push_back(d);
          rec_exp.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    mem_req = '{addr: addr, wr_en: 1'b1, wr_data: data};
    @(posedge clk);
    #1;
    mem_req.wr_en = 1'b0;
    case (addr)
      hex_l_addr: hex_l_model.raw = data;
      hex_h_addr: hex_h_model = data[7:0];
      ledr_addr:  ledr_model = data[9:0];
      music_addr: music_model = data[1:0];
      default:    ;
    endcase
    check_outputs();
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [15:0] exp, input logic below);
    @(posedge clk);
    #1;
    mem_req = '{addr: addr, wr_en: 1'b0, wr_data: 16'h0000};
    @(negedge clk);
    check_word(rd_data, exp, below, $sformatf("read of 0x%04h", addr));
  endtask

  // two synchroniser stages plus one spare edge.
  task automatic drive_inputs(input board_in_t value);
    @(posedge clk);
    #1;
    board_in = value;
    repeat (3) @(posedge clk);
  endtask

  task automatic run_record(input int i);
    logic [31:0] v;
    logic [31:0] d;
    logic [31:0] e;
    v = rec_val[i];
    d = rec_data[i];
    e = rec_exp[i];
    case (rec_op[i])
      "W":     write_word(v[15:0], d[15:0]);
      "R":     read_check(v[15:0], e[15:0], d[0]);
      "I":     drive_inputs(v[17:0]);
      default: begin
        errors++;
        $display("stimulus record %0d has an unknown operation", i);
      end
    endcase
  endtask

  initial begin
    reset_n         = 1'b0;
    mem_req         = '0;
    board_in        = '0;
    errors          = 0;
    loaded          = 1'b0;
    hex_l_model.raw = '0;
    hex_h_model     = '0;
    ledr_model      = '0;
    music_model     = '0;
    load_records(opened);
    if (!opened) begin
      $display("could not open the stimulus file tests/board_io_stim.txt");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      timeout_cycles = rec_op.size() * 10 + 100;
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      reset_n = 1'b1;
      check_outputs();
      foreach (rec_op[i]) begin
        run_record(i);
      end
      errors += board_io_top_inst.io_mapping_inst.board_io_properties_inst.fail_count;
      $display("Summary: %0d records, %0d errors", rec_op.size(), errors);
      if (errors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

  // the watchdog budget grows with the number of records.
  initial begin
    wait (loaded);
    repeat (timeout_cycles) @(posedge clk);
    $display("the run timed out after %0d cycles", timeout_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== tests/board_io_stim.txt ====
# columns: op value data expected, all hex. W writes data to address value, I drives value onto board_in.
# R reads address value: data 0 wants rd_data equal to expected, data 1 wants it below expected.
R FFFB 0 0000
R FFFC 0 0000
R FFFD 0 0000
R FFF8 0 0000
W FFFB 3A5F 0
R FFFB 0 3A5F
W FFFC BEEF 0
R FFFC 0 00EF
W FFFD FFFF 0
R FFFD 0 03FF
W FFF8 ABCF 0
R FFF8 0 0003
I 2AB56 0 0
R FFFF 0 02B5
R FFFE 0 000A
R FFF7 0 0006
W FFFF 1234 0
R FFFF 0 02B5
R 0000 0 0000
R FFF0 0 0000
R FFFA 1 0014
R FFF9 1 000A

// ==== flist.f ====
rtl/board_pkg.sv
rtl/io_map_pkg.sv
rtl/input_sync.sv
rtl/scan_counter.sv
rtl/seven_seg_decoder.sv
rtl/io_mapping.sv
rtl/board_io_top.sv
tests/board_io_properties.sv
tests/board_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the board I/O testbench with Verilator, run it and check the log.
log=sim.log

verilator --binary --timing --assert -f flist.f --top-module board_io_tb \
  -Mdir obj_dir -o board_io_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/board_io_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation passed"
exit 0
